/* filelist.f */
+incdir+include
source/pulsePkg.sv
source/tapBusIf.sv
source/symbolDelayLine.sv
source/polyphaseFolder.sv
source/partialSumTree.sv
source/pulseShaper.sv
verification/pulseShaperTb.sv

/* include/pulseShaper_macros.svh */
`ifndef PULSE_SHAPER_MACROS_SVH
`define PULSE_SHAPER_MACROS_SVH

// filter geometry
`define PULSE_TAPS 33
// samples per symbol
`define PULSE_PHASES 4
// symmetric pairs plus the centre tap
`define FOLDED_TAPS 17

// datapath
`define SAMPLE_WIDTH 18
`define GROUP_COUNT 5

`endif

/* runSim.sh */
#!/bin/sh
# Build and run the pulse shaper testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module pulseShaperTb \
	-Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* source/partialSumTree.sv */
`timescale 1ns/100ps
`default_nettype none
`include "pulseShaper_macros.svh"

module partialSumTree
	import pulsePkg::*;
(
	input logic sys_clk,
	input logic rstN,
	input logic foldEna,
	input foldedArrayT foldedSums,
	output sampleT sampleOut
);

	// folded values per full group, centre sits in the last group
	localparam int groupSize = (`FOLDED_TAPS - 1) / (`GROUP_COUNT - 1);

	sampleT groupNext [`GROUP_COUNT];
	sampleT groupSums [`GROUP_COUNT];
	sampleT totalNext;

	//**********************************************************
	// first stage, four groups of four plus the centre

	always_comb
	begin
		for (int g = 0; g < `GROUP_COUNT - 1; g++)
			groupNext[g] = (foldedSums[g*groupSize] + foldedSums[g*groupSize + 1])
				+ (foldedSums[g*groupSize + 2] + foldedSums[g*groupSize + 3]);
		groupNext[`GROUP_COUNT - 1] = foldedSums[`FOLDED_TAPS - 1];
	end

	//**********************************************************
	// second stage into the output sample

	always_comb
	begin
		totalNext = ((groupSums[0] + groupSums[1]) + (groupSums[2] + groupSums[3]))
			+ groupSums[4];
	end

	always_ff @(posedge sys_clk)
	begin
		if (!rstN)
		begin
			groupSums <= '{default: '0};
			sampleOut <= '0;
		end
		else if (foldEna)
		begin
			groupSums <= groupNext;
			sampleOut <= totalNext; // groups from the previous enable
		end
	end

	// output held over any gap between enables
	outputHold: assert property (@(posedge sys_clk) disable iff (!rstN)
		!foldEna |=> $stable(sampleOut))
		else $error("sampleOut changed without an enable");

endmodule

`default_nettype wire

/* source/polyphaseFolder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "pulseShaper_macros.svh"

module polyphaseFolder
	import pulsePkg::*;
(
	input logic sys_clk,
	input logic rstN,
	tapBusIf.sink tapBus,
	output foldedArrayT foldedSums,
	output logic foldEna
);

	sampleT tapTerms [`PULSE_TAPS];
	foldedArrayT foldNext;

	// level times coefficient, 3c built as c + 2c
	function automatic sampleT levelTerm(symbolCodeT code, sampleT coeff);
		sampleT triple;
		triple = coeff + (coeff <<< 1);
		case (code)
			symPos3:
				return triple;
			symPos1:
				return coeff;
			symNeg1:
				return -coeff;
			symNeg3:
				return -triple;
			default:
				return '0;
		endcase
	endfunction

	//**********************************************************
	// phase-gated taps

	always_comb
	begin
		for (int i = 0; i < `PULSE_TAPS; i++)
		begin
			if (tapBus.tapValid[i] && tapBus.phase == phaseT'(i % `PULSE_PHASES))
				tapTerms[i] = levelTerm(tapBus.taps[i],
					innerCoeff[(i < `FOLDED_TAPS) ? i : `PULSE_TAPS - 1 - i]);
			else
				tapTerms[i] = '0; // empty or off-phase
		end
	end

	//**********************************************************
	// symmetric fold, tap k pairs with tap 32-k

	always_comb
	begin
		for (int k = 0; k < `FOLDED_TAPS - 1; k++)
			foldNext[k] = tapTerms[k] + tapTerms[`PULSE_TAPS - 1 - k];
		foldNext[`FOLDED_TAPS - 1] = tapTerms[`FOLDED_TAPS - 1]; // centre alone
	end

	always_ff @(posedge sys_clk)
	begin
		if (!rstN)
			foldedSums <= '{default: '0};
		else if (tapBus.sampleEna)
			foldedSums <= foldNext;
	end

	// tree advances on the same enable as this register
	assign foldEna = tapBus.sampleEna;

	// newest loaded symbol must be a real code when it is consumed
	symbolKnown: assert property (@(posedge sys_clk) disable iff (!rstN)
		tapBus.sampleEna && tapBus.tapValid[0] |-> !$isunknown(tapBus.taps[0]))
		else $error("unknown symbol code in the delay line at an enable");

endmodule

`default_nettype wire

/* source/pulsePkg.sv */
`default_nettype none
`include "pulseShaper_macros.svh"

package pulsePkg;

	// four-level symbol codes
	typedef enum logic [1:0]
	{
		symPos3 = 2'd0,
		symPos1 = 2'd1,
		symNeg1 = 2'd2,
		symNeg3 = 2'd3
	} symbolCodeT;

	typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;
	typedef logic [$clog2(`PULSE_PHASES)-1:0] phaseT;

	typedef symbolCodeT symbolArrayT [`PULSE_TAPS];
	typedef sampleT foldedArrayT [`FOLDED_TAPS];

	//**********************************************************
	// inner level only, outer level is 3x
	localparam sampleT innerCoeff [`FOLDED_TAPS] = '{
		-18'sd425,
		18'sd401,
		18'sd1125,
		18'sd1218,
		18'sd471,
		-18'sd790,
		-18'sd1812,
		-18'sd1816,
		-18'sd507,
		18'sd1604,
		18'sd3304,
		18'sd3217,
		18'sd529,
		-18'sd4471,
		-18'sd10353,
		-18'sd15080,
		-18'sd16887 // centre tap
	};

endpackage

`default_nettype wire

/* source/pulseShaper.sv */
`timescale 1ns/100ps
`default_nettype none
`include "pulseShaper_macros.svh"

module pulseShaper
	import pulsePkg::*;
(
	input logic sys_clk,
	input logic rstN,
	input logic sampleEna,
	input logic [1:0] symbolIn,
	output logic signed [`SAMPLE_WIDTH-1:0] sampleOut
);

	foldedArrayT foldedSums;
	logic foldEna;

	tapBusIf tapBus();

	//**********************************************************
	// input side

	symbolDelayLine delayLine
	(
		.sys_clk (sys_clk),
		.rstN (rstN),
		.sampleEna (sampleEna),
		.symbolIn (symbolCodeT'(symbolIn)),
		.tapBus (tapBus.source)
	);

	//**********************************************************
	// fold and sum

	polyphaseFolder folder
	(
		.sys_clk (sys_clk),
		.rstN (rstN),
		.tapBus (tapBus.sink),
		.foldedSums (foldedSums),
		.foldEna (foldEna)
	);

	partialSumTree sumTree
	(
		.sys_clk (sys_clk),
		.rstN (rstN),
		.foldEna (foldEna),
		.foldedSums (foldedSums),
		.sampleOut (sampleOut)
	);

endmodule

`default_nettype wire

/* source/symbolDelayLine.sv */
`timescale 1ns/100ps
`default_nettype none
`include "pulseShaper_macros.svh"

module symbolDelayLine
	import pulsePkg::*;
(
	input logic sys_clk,
	input logic rstN,
	input logic sampleEna,
	input symbolCodeT symbolIn,
	tapBusIf.source tapBus
);

	phaseT phase;
	symbolArrayT taps;
	logic [`PULSE_TAPS-1:0] tapValid;

	//**********************************************************
	// phase counter, symbol line and valid line step together

	always_ff @(posedge sys_clk)
	begin
		if (!rstN)
		begin
			phase <= '0;
			tapValid <= '0;
			for (int i = 0; i < `PULSE_TAPS; i++)
				taps[i] <= symPos3;
		end
		else if (sampleEna)
		begin
			phase <= phase + 1'b1; // wraps at the phase count
			tapValid <= {tapValid[`PULSE_TAPS-2:0], 1'b1};
			taps[0] <= symbolIn;
			for (int i = 1; i < `PULSE_TAPS; i++)
				taps[i] <= taps[i-1];
		end
	end

	//**********************************************************
	// state seen by the folder

	assign tapBus.sampleEna = sampleEna;
	assign tapBus.phase = phase;
	assign tapBus.taps = taps;
	assign tapBus.tapValid = tapValid;

	// one phase step per enable, never skipped or repeated
	phaseStep: assert property (@(posedge sys_clk) disable iff (!rstN)
		sampleEna |=> phase == phaseT'($past(phase) + 1'b1))
		else $error("phase did not advance by one across an enable");

endmodule

`default_nettype wire

/* source/tapBusIf.sv */
`timescale 1ns/100ps
`default_nettype none
`include "pulseShaper_macros.svh"

interface tapBusIf
	import pulsePkg::*;
();

	logic sampleEna;
	phaseT phase;
	symbolArrayT taps;
	logic [`PULSE_TAPS-1:0] tapValid; // set once a tap has been loaded

	modport source
	(
		output sampleEna,
		output phase,
		output taps,
		output tapValid
	);

	modport sink
	(
		input sampleEna,
		input phase,
		input taps,
		input tapValid
	);

endinterface

`default_nettype wire

/* verification/pulseShaperTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "pulseShaper_macros.svh"

module pulseShaperTb
	import pulsePkg::*;
();

	localparam int waitLimit = 200; // cycles per wait loop
	localparam int scaleStart = 40; // all taps valid and flushed

	logic sys_clk;
	logic rstN;
	logic sampleEna;
	logic [1:0] symbolIn;
	sampleT sampleOut;

	logic [15:0] lfsrState = 16'd36; // seed
	string testName = "idle";
	int valueErrors = 0;
	int startupErrors = 0;
	int holdErrors = 0;
	int mirrorErrors = 0;
	int scaleErrors = 0;
	int timeoutErrors = 0;

	// reference model of the delay line
	symbolCodeT modelTaps [`PULSE_TAPS];
	logic modelValid [`PULSE_TAPS];
	int modelPhase;
	sampleT outputQueue [$];

	logic enaSeen = 1'b0; // enable at the last rising edge
	logic holdSeen = 1'b0;
	int enaSinceReset = 0;
	int enaNumber;
	int sentSinceReset = 0;
	sampleT expectedOut = '0;
	logic recordMode = 1'b0;
	logic mirrorMode = 1'b0;
	logic scaleRecord = 1'b0;
	logic scaleCheck = 1'b0;
	sampleT recordedOut [0:1023];
	symbolCodeT recordedSyms [0:127];
	sampleT mirrorRef = '0;
	sampleT pos1ByPhase [`PULSE_PHASES];
	sampleT scaleRef = '0;

	pulseShaper UUT
	(
		.sys_clk (sys_clk),
		.rstN (rstN),
		.sampleEna (sampleEna),
		.symbolIn (symbolIn),
		.sampleOut (sampleOut)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	//**********************************************************
	// stimulus helpers

	function automatic logic nextRandomBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 16'hB400; // galois taps 16,14,13,11
		return outBit;
	endfunction

	function automatic int randomBits(int count);
		int value;
		value = 0;
		for (int b = 0; b < count; b++)
			value = (value << 1) | int'(nextRandomBit());
		return value;
	endfunction

	function automatic symbolCodeT invertSymbol(symbolCodeT code);
		case (code)
			symPos3:
				return symNeg3;
			symPos1:
				return symNeg1;
			symNeg1:
				return symPos1;
			default:
				return symPos3;
		endcase
	endfunction

	task idleCycles(int count);
		repeat (count)
		begin
			@(negedge sys_clk);
			sampleEna = 1'b0;
		end
	endtask

	task sendSymbol(symbolCodeT code);
		@(negedge sys_clk);
		sampleEna = 1'b1;
		symbolIn = code;
		sentSinceReset++;
	endtask

	// source holds each symbol for four enables
	task sendHeldSymbol(symbolCodeT code);
		repeat (`PULSE_PHASES)
		begin
			sendSymbol(code);
			idleCycles(randomBits(3));
		end
	endtask

	task applyReset();
		@(negedge sys_clk);
		rstN = 1'b0;
		sampleEna = 1'b0;
		repeat (2) @(negedge sys_clk);
		rstN = 1'b1;
		sentSinceReset = 0;
	endtask

	task finishRun();
		int total;
		total = valueErrors + startupErrors + holdErrors + mirrorErrors + scaleErrors
			+ timeoutErrors;
		$display("errors: value %0d, startup %0d, hold %0d, mirror %0d, scale %0d, timeout %0d",
			valueErrors, startupErrors, holdErrors, mirrorErrors, scaleErrors, timeoutErrors);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	// also waits out the falling edge that captures the last output
	task automatic awaitSentEnables();
		int cycles;
		cycles = 0;
		idleCycles(1);
		while ((enaSinceReset < sentSinceReset || enaSeen) && cycles < waitLimit)
		begin
			@(negedge sys_clk);
			cycles++;
		end
		if (enaSinceReset < sentSinceReset || enaSeen)
		begin
			timeoutErrors++;
			$display("timed out in %s waiting for enable %0d to reach the DUT",
				testName, sentSinceReset);
			finishRun();
		end
	endtask

	//**********************************************************
	// reference model built from the tap table

	task advanceModel(symbolCodeT code);
		for (int i = `PULSE_TAPS - 1; i > 0; i--)
		begin
			modelTaps[i] = modelTaps[i-1];
			modelValid[i] = modelValid[i-1];
		end
		modelTaps[0] = code;
		modelValid[0] = 1'b1;
		modelPhase = (modelPhase + 1) % `PULSE_PHASES;
	endtask

	function automatic sampleT modelOutput();
		int acc;
		int coeff;
		int idx;
		acc = 0;
		for (int i = 0; i < `PULSE_TAPS; i++)
		begin
			if (modelValid[i] && modelPhase == i % `PULSE_PHASES)
			begin
				idx = (i < `PULSE_TAPS - 1 - i) ? i : `PULSE_TAPS - 1 - i;
				coeff = int'(innerCoeff[idx]);
				case (modelTaps[i])
					symPos3:
						acc += 3 * coeff;
					symPos1:
						acc += coeff;
					symNeg1:
						acc -= coeff;
					default:
						acc -= 3 * coeff;
				endcase
			end
		end
		return sampleT'(acc);
	endfunction

	always @(posedge sys_clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `PULSE_TAPS; i++)
			begin
				modelTaps[i] = symPos3;
				modelValid[i] = 1'b0;
			end
			modelPhase = 0;
			outputQueue.delete();
			repeat (3) outputQueue.push_back(sampleT'(0)); // pipeline holds zeros
			enaSeen <= 1'b0;
			holdSeen <= 1'b0;
			enaSinceReset <= 0;
			expectedOut <= '0;
		end
		else
		begin
			enaSeen <= sampleEna;
			holdSeen <= !sampleEna;
			if (sampleEna)
			begin
				enaNumber = enaSinceReset + 1;
				enaSinceReset <= enaNumber;
				advanceModel(symbolCodeT'(symbolIn));
				outputQueue.push_back(modelOutput());
				expectedOut <= outputQueue.pop_front(); // state three enables back
				mirrorRef <= -recordedOut[enaNumber];
				scaleRef <= sampleT'(3 * pos1ByPhase[enaNumber % `PULSE_PHASES]);
			end
		end
	end

	// outputs captured while stable at the falling edge
	always @(negedge sys_clk)
	begin
		if (rstN && enaSeen && recordMode)
			recordedOut[enaSinceReset] = sampleOut;
		if (rstN && enaSeen && scaleRecord && enaSinceReset >= scaleStart)
			pos1ByPhase[enaSinceReset % `PULSE_PHASES] = sampleOut;
	end

	//**********************************************************
	// checks

	valueMatch: assert property (@(negedge sys_clk) disable iff (!rstN)
		enaSeen |-> sampleOut == expectedOut)
		else
		begin
			valueErrors++;
			$display("error %s: expected %0d, actual %0d", testName, expectedOut, sampleOut);
		end

	startupZero: assert property (@(negedge sys_clk) disable iff (!rstN)
		enaSinceReset <= 3 |-> sampleOut == '0)
		else
		begin
			startupErrors++;
			$display("error %s startup: expected 0, actual %0d", testName, sampleOut);
		end

	outputHold: assert property (@(negedge sys_clk) disable iff (!rstN)
		holdSeen |-> $stable(sampleOut))
		else
		begin
			holdErrors++;
			$display("sampleOut changed between enables during %s", testName);
		end

	mirrorMatch: assert property (@(negedge sys_clk) disable iff (!rstN)
		mirrorMode && enaSeen |-> sampleOut == mirrorRef)
		else
		begin
			mirrorErrors++;
			$display("error %s: expected %0d, actual %0d", testName, mirrorRef, sampleOut);
		end

	scaleMatch: assert property (@(negedge sys_clk) disable iff (!rstN)
		scaleCheck && enaSeen && enaSinceReset >= scaleStart |-> sampleOut == scaleRef)
		else
		begin
			scaleErrors++;
			$display("error %s: expected %0d, actual %0d", testName, scaleRef, sampleOut);
		end

	//**********************************************************
	// test sequence

	initial
	begin
		rstN = 1'b0;
		sampleEna = 1'b0;
		symbolIn = 2'd0;
		applyReset();
		idleCycles(5); // output must sit at zero before any enable

		testName = "startup";
		for (int s = 0; s < 10; s++)
			sendHeldSymbol(symbolCodeT'(randomBits(2)));

		testName = "random";
		for (int s = 0; s < 150; s++)
		begin
			if (s == 75)
			begin
				applyReset(); // second reset mid-stream
				testName = "restart";
			end
			sendHeldSymbol(symbolCodeT'(randomBits(2)));
		end
		awaitSentEnables();

		// same stream twice with the second pass inverted
		applyReset();
		testName = "record";
		recordMode = 1'b1;
		for (int s = 0; s < 60; s++)
		begin
			recordedSyms[s] = symbolCodeT'(randomBits(2));
			sendHeldSymbol(recordedSyms[s]);
		end
		awaitSentEnables();
		recordMode = 1'b0;
		applyReset();
		testName = "mirror";
		mirrorMode = 1'b1;
		for (int s = 0; s < 60; s++)
			sendHeldSymbol(invertSymbol(recordedSyms[s]));
		awaitSentEnables();
		mirrorMode = 1'b0;

		// outer level against inner level per phase
		applyReset();
		testName = "scale pos1";
		scaleRecord = 1'b1;
		repeat (12) sendHeldSymbol(symPos1);
		awaitSentEnables();
		scaleRecord = 1'b0;
		applyReset();
		testName = "scale pos3";
		scaleCheck = 1'b1;
		repeat (12) sendHeldSymbol(symPos3);
		awaitSentEnables();
		scaleCheck = 1'b0;

		idleCycles(4);
		finishRun();
	end

endmodule

`default_nettype wire
